// File: hw/renameIdPkg.sv
////////////////////////////////////////
// Buffer ID space of the rename unit
// ID width, rename window bounds and
// physical buffer count with index type
////////////////////////////////////////

`default_nettype none

package renameIdPkg;

	////////////////////////////////////////
	// Architectural and physical IDs

	// Width of any buffer ID
	localparam int archIdWidth = 5;

	// One type for both architectural and physical IDs
	typedef logic [archIdWidth-1:0] archId_t;

	////////////////////////////////////////
	// Rename window

	// IDs in [renameBase, renameLimit) name global buffers
	localparam archId_t renameBase = archId_t'(8);
	localparam archId_t renameLimit = archId_t'(24);

	// Physical buffer n carries ID renameBase + n
	localparam int numBuffers = 8;

	// Index of one physical buffer
	typedef logic [$clog2(numBuffers)-1:0] bufIdx_t;

endpackage

`default_nettype wire

// File: hw/renameTablePkg.sv
////////////////////////////////////////
// Rename table geometry
// Depth, slot index and occupancy types
////////////////////////////////////////

`default_nettype none

package renameTablePkg;

	// Number of in-flight rename entries
	localparam int tableDepth = 8;

	// Ring slot index, wraps naturally at depth 8
	typedef logic [$clog2(tableDepth)-1:0] slotIdx_t;

	// Occupancy, 0 up to tableDepth inclusive
	typedef logic [$clog2(tableDepth+1)-1:0] count_t;

endpackage

`default_nettype wire

// File: hw/freeBufferList.sv
////////////////////////////////////////
// Free list of physical buffers
// In-use bits, lowest-free priority pick
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module freeBufferList (
	input logic clock,
	input logic reset,

	// Take freeIdx this cycle
	input logic allocValid,

	// Return a buffer from the retiring entry
	input logic releaseValid,
	input renameIdPkg::bufIdx_t releaseIdx,

	// Lowest free buffer, valid while freeAvail
	output logic freeAvail,
	output renameIdPkg::bufIdx_t freeIdx
);

	// One bit per physical buffer, set while held by a table entry
	logic [renameIdPkg::numBuffers-1:0] inUse;

	////////////////////////////////////////
	// Lowest-index priority encoder

	// Scan top down so the lowest free index is the last written
	always_comb begin
		freeIdx = '0;
		for (int i = renameIdPkg::numBuffers - 1; i >= 0; i--) begin
			if (!inUse[i]) begin
				freeIdx = renameIdPkg::bufIdx_t'(i);
			end
		end
	end

	// Any zero bit means a buffer can be handed out
	assign freeAvail = ~(&inUse);

	////////////////////////////////////////
	// In-use state

	// Alloc and release never target the same bit
	// alloc picks a clear bit, release names a set one
	always_ff @(posedge clock) begin
		if (reset) begin
			inUse <= '0;
		end else begin
			if (releaseValid) begin
				inUse[releaseIdx] <= 1'b0;
			end
			if (allocValid) begin
				inUse[freeIdx] <= 1'b1;
			end
		end
	end

	// Table must only hand back buffers it actually holds
	releaseHeldOnly: assert property (@(posedge clock) disable iff (reset)
		releaseValid |-> inUse[releaseIdx]);

	// Issue logic must gate allocation on freeAvail
	allocOnlyWhenFree: assert property (@(posedge clock) disable iff (reset)
		allocValid |-> freeAvail);

endmodule

`default_nettype wire

// File: hw/renameTable.sv
////////////////////////////////////////
// In-order rename table
// Ring of entries, head/tail pointers,
// occupancy count and full/empty status
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module renameTable (
	input logic clock,
	input logic reset,

	// New entry from the issue stage, written at the tail
	input logic writeValid,
	input renameIdPkg::archId_t writeDst,
	input renameIdPkg::archId_t writePhys,
	input logic writeRenamed,
	input renameIdPkg::bufIdx_t writeBuf,

	// Release channel, retires the head entry
	input logic relValid,
	output logic relReady,

	// Status
	output logic full,
	output logic empty,
	output logic tableFull,

	// Entry view for the source lookup
	output logic [renameTablePkg::tableDepth-1:0] entryValid,
	output renameIdPkg::archId_t entryDst [renameTablePkg::tableDepth],
	output renameIdPkg::archId_t entryPhys [renameTablePkg::tableDepth],
	output renameTablePkg::slotIdx_t tailIdx,

	// Buffer returned to the free list
	output logic releaseValid,
	output renameIdPkg::bufIdx_t releaseIdx
);

	// Per-entry buffer ownership
	logic entryRenamed [renameTablePkg::tableDepth];
	renameIdPkg::bufIdx_t entryBuf [renameTablePkg::tableDepth];

	renameTablePkg::slotIdx_t headIdx;
	renameTablePkg::count_t count;
	renameTablePkg::count_t countNext;
	logic relFire;

	////////////////////////////////////////
	// Handshake and status

	assign tableFull = (count == renameTablePkg::count_t'(renameTablePkg::tableDepth));
	assign relReady = (count != '0);
	assign relFire = relValid & relReady;

	// Only renamed entries own a buffer
	assign releaseValid = relFire & entryRenamed[headIdx];
	assign releaseIdx = entryBuf[headIdx];

	// Write and release on one edge cancel in the count
	always_comb begin
		countNext = count;
		if (writeValid && !relFire) begin
			countNext = count + 1'b1;
		end else if (!writeValid && relFire) begin
			countNext = count - 1'b1;
		end
	end

	////////////////////////////////////////
	// Ring control state

	always_ff @(posedge clock) begin
		if (reset) begin
			headIdx <= '0;
			tailIdx <= '0;
			count <= '0;
			entryValid <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			count <= countNext;
			full <= (countNext == renameTablePkg::count_t'(renameTablePkg::tableDepth));
			empty <= (countNext == '0);
			if (relFire) begin
				entryValid[headIdx] <= 1'b0;
				headIdx <= headIdx + 1'b1;
			end
			// Head and tail coincide only when empty or full, so no clash here
			if (writeValid) begin
				entryValid[tailIdx] <= 1'b1;
				tailIdx <= tailIdx + 1'b1;
			end
		end
	end

	// Entry payload, meaningful only under entryValid
	always_ff @(posedge clock) begin
		if (writeValid) begin
			entryDst[tailIdx] <= writeDst;
			entryPhys[tailIdx] <= writePhys;
			entryRenamed[tailIdx] <= writeRenamed;
			entryBuf[tailIdx] <= writeBuf;
		end
	end

	// Issue stage must see tableFull before writing
	noWriteWhenFull: assert property (@(posedge clock) disable iff (reset)
		writeValid |-> !tableFull);

	// A retired head must be a live entry
	noReleaseWhenEmpty: assert property (@(posedge clock) disable iff (reset)
		relFire |-> entryValid[headIdx]);

endmodule

`default_nettype wire

// File: hw/sourceLookup.sv
////////////////////////////////////////
// Source rename lookup
// Youngest in-flight producer of reqSrc
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sourceLookup (
	input renameIdPkg::archId_t reqSrc,

	// Current table contents, before this cycle's write
	input logic [renameTablePkg::tableDepth-1:0] entryValid,
	input renameIdPkg::archId_t entryDst [renameTablePkg::tableDepth],
	input renameIdPkg::archId_t entryPhys [renameTablePkg::tableDepth],
	input renameTablePkg::slotIdx_t tailIdx,

	// Physical source, reqSrc itself when nothing matches
	output renameIdPkg::archId_t srcPhys
);

	// Hit per slot
	logic [renameTablePkg::tableDepth-1:0] hit;

	always_comb begin
		for (int i = 0; i < renameTablePkg::tableDepth; i++) begin
			hit[i] = entryValid[i] && (entryDst[i] == reqSrc);
		end
	end

	////////////////////////////////////////
	// Age ranking from the tail

	// Age 0 is the slot just behind the tail, the youngest entry
	// Walk oldest to youngest so the youngest hit is written last
	always_comb begin
		renameTablePkg::slotIdx_t slot;
		srcPhys = reqSrc;
		for (int age = renameTablePkg::tableDepth - 1; age >= 0; age--) begin
			slot = tailIdx - renameTablePkg::slotIdx_t'(age) - 1'b1;
			if (hit[slot]) begin
				srcPhys = entryPhys[slot];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/renameIssue.sv
////////////////////////////////////////
// Issue stage of the rename unit
// Acceptance, destination rename and
// the one-deep response register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module renameIssue (
	input logic clock,
	input logic reset,

	// Request channel from the decoder
	input logic reqValid,
	output logic reqReady,
	input renameIdPkg::archId_t reqDst,
	input renameIdPkg::archId_t reqSrc,

	// Response channel
	output logic rspValid,
	input logic rspReady,
	output renameIdPkg::archId_t rspDst,
	output renameIdPkg::archId_t rspSrc,

	// Table and free list state
	input logic tableFull,
	input logic freeAvail,
	input renameIdPkg::bufIdx_t freeIdx,
	input renameIdPkg::archId_t srcPhys,

	// Side effects of an accepted request
	output logic allocValid,
	output logic writeValid,
	output renameIdPkg::archId_t writeDst,
	output renameIdPkg::archId_t writePhys,
	output logic writeRenamed,
	output renameIdPkg::bufIdx_t writeBuf
);

	logic inWindow;
	logic rspFree;
	logic accept;
	renameIdPkg::archId_t physDst;

	////////////////////////////////////////
	// Acceptance

	assign inWindow = (reqDst >= renameIdPkg::renameBase) && (reqDst < renameIdPkg::renameLimit);

	// Response slot empty or draining this cycle
	assign rspFree = !rspValid || rspReady;

	// Independent of reqValid by construction
	assign reqReady = !tableFull && rspFree && (!inWindow || freeAvail);
	assign accept = reqValid && reqReady;

	// Window IDs get the lowest free buffer, others pass through
	assign physDst = inWindow ? renameIdPkg::renameBase + renameIdPkg::archId_t'(freeIdx) : reqDst;

	assign allocValid = accept && inWindow;
	assign writeValid = accept;
	assign writeDst = reqDst;
	assign writePhys = physDst;
	assign writeRenamed = inWindow;
	assign writeBuf = freeIdx;

	////////////////////////////////////////
	// Response register

	always_ff @(posedge clock) begin
		if (reset) begin
			rspValid <= 1'b0;
		end else if (accept) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rspDst <= physDst;
			rspSrc <= srcPhys;
		end
	end

	// Held response under back-pressure
	rspStable: assert property (@(posedge clock) disable iff (reset)
		rspValid && !rspReady |=> rspValid && $stable(rspDst) && $stable(rspSrc));

endmodule

`default_nettype wire

// File: hw/renameUnit.sv
////////////////////////////////////////
// Rename unit top level
// Issue stage, free list, rename table
// and source lookup
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module renameUnit (
	input logic clock,
	input logic reset,

	// Request channel
	input logic reqValid,
	output logic reqReady,
	input renameIdPkg::archId_t reqDst,
	input renameIdPkg::archId_t reqSrc,

	// Response channel
	output logic rspValid,
	input logic rspReady,
	output renameIdPkg::archId_t rspDst,
	output renameIdPkg::archId_t rspSrc,

	// Release channel
	input logic relValid,
	output logic relReady,

	// Table status
	output logic full,
	output logic empty
);

	// Issue to free list
	logic allocValid;
	logic freeAvail;
	renameIdPkg::bufIdx_t freeIdx;

	// Issue to table
	logic writeValid;
	renameIdPkg::archId_t writeDst;
	renameIdPkg::archId_t writePhys;
	logic writeRenamed;
	renameIdPkg::bufIdx_t writeBuf;
	logic tableFull;

	// Table to lookup and free list
	logic [renameTablePkg::tableDepth-1:0] entryValid;
	renameIdPkg::archId_t entryDst [renameTablePkg::tableDepth];
	renameIdPkg::archId_t entryPhys [renameTablePkg::tableDepth];
	renameTablePkg::slotIdx_t tailIdx;
	logic releaseValid;
	renameIdPkg::bufIdx_t releaseIdx;

	// Lookup result back to issue
	renameIdPkg::archId_t srcPhys;

	renameIssue issue (
		.clock(clock), .reset(reset),
		.reqValid(reqValid), .reqReady(reqReady), .reqDst(reqDst), .reqSrc(reqSrc),
		.rspValid(rspValid), .rspReady(rspReady), .rspDst(rspDst), .rspSrc(rspSrc),
		.tableFull(tableFull), .freeAvail(freeAvail), .freeIdx(freeIdx),
		.srcPhys(srcPhys), .allocValid(allocValid), .writeValid(writeValid),
		.writeDst(writeDst), .writePhys(writePhys), .writeRenamed(writeRenamed),
		.writeBuf(writeBuf)
	);

	freeBufferList freeList (
		.clock(clock), .reset(reset), .allocValid(allocValid),
		.releaseValid(releaseValid), .releaseIdx(releaseIdx),
		.freeAvail(freeAvail), .freeIdx(freeIdx)
	);

	renameTable table0 (
		.clock(clock), .reset(reset),
		.writeValid(writeValid), .writeDst(writeDst), .writePhys(writePhys),
		.writeRenamed(writeRenamed), .writeBuf(writeBuf),
		.relValid(relValid), .relReady(relReady),
		.full(full), .empty(empty), .tableFull(tableFull),
		.entryValid(entryValid), .entryDst(entryDst), .entryPhys(entryPhys),
		.tailIdx(tailIdx), .releaseValid(releaseValid), .releaseIdx(releaseIdx)
	);

	// Sees the table before this cycle's write
	sourceLookup lookup (
		.reqSrc(reqSrc), .entryValid(entryValid), .entryDst(entryDst),
		.entryPhys(entryPhys), .tailIdx(tailIdx), .srcPhys(srcPhys)
	);

endmodule

`default_nettype wire

// File: sim/renameChecker.sv
////////////////////////////////////////
// Checker for the rename unit
// Entry queue, free bitmap, reference
// function and per-cycle comparison
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module renameChecker (
	input logic clock,
	input logic reset,
	input logic reqValid,
	input logic reqReady,
	input renameIdPkg::archId_t reqDst,
	input renameIdPkg::archId_t reqSrc,
	input logic rspValid,
	input logic rspReady,
	input renameIdPkg::archId_t rspDst,
	input renameIdPkg::archId_t rspSrc,
	input logic relValid,
	input logic relReady,
	input logic full,
	input logic empty
);

	// Set by the testbench at the start of each test
	string testName = "reset";
	int checkCount = 0;
	int errorCount = 0;

	////////////////////////////////////////
	// Model state

	// In-flight entries, oldest first; buffer -1 means not renamed
	renameIdPkg::archId_t modelDst [$];
	renameIdPkg::archId_t modelPhys [$];
	int modelBuf [$];

	// Responses owed to the decoder
	renameIdPkg::archId_t expDstQ [$];
	renameIdPkg::archId_t expSrcQ [$];

	logic [renameIdPkg::numBuffers-1:0] busy;

	function automatic logic insideWindow(input renameIdPkg::archId_t id);
		return (id >= renameIdPkg::renameBase) && (id < renameIdPkg::renameLimit);
	endfunction

	// Lowest clear bit, -1 when all buffers are held
	function automatic int lowestFree();
		for (int i = 0; i < renameIdPkg::numBuffers; i++) begin
			if (!busy[i]) return i;
		end
		return -1;
	endfunction

	// Expected response for a request accepted against the current model
	function automatic void expectedResponse(input renameIdPkg::archId_t dst,
		input renameIdPkg::archId_t src, output renameIdPkg::archId_t expDst,
		output renameIdPkg::archId_t expSrc);
		expDst = dst;
		expSrc = src;
		if (insideWindow(dst)) begin
			expDst = renameIdPkg::renameBase + renameIdPkg::archId_t'(lowestFree());
		end
		// Later entries are younger, so the last hit wins
		for (int i = 0; i < modelDst.size(); i++) begin
			if (modelDst[i] == src) expSrc = modelPhys[i];
		end
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		checkCount++;
		if (expected != actual) begin
			errorCount++;
			$display("[FAIL] %s %s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Comparison at the falling edge

	// Inputs and outputs are settled here; fires happen at the next rising edge
	always @(negedge clock) begin
		logic readyExp;
		logic reqFire;
		logic relFire;
		int allocIdx;
		renameIdPkg::archId_t newDst;
		renameIdPkg::archId_t newSrc;
		if (reset) begin
			modelDst.delete();
			modelPhys.delete();
			modelBuf.delete();
			expDstQ.delete();
			expSrcQ.delete();
			busy = '0;
		end else begin
			readyExp = (modelDst.size() < renameTablePkg::tableDepth)
				&& (expDstQ.size() == 0 || rspReady)
				&& (!insideWindow(reqDst) || lowestFree() >= 0);
			checkValue("rspValid", int'(expDstQ.size() != 0), int'(rspValid));
			checkValue("relReady", int'(modelDst.size() != 0), int'(relReady));
			checkValue("full", int'(modelDst.size() == renameTablePkg::tableDepth), int'(full));
			checkValue("empty", int'(modelDst.size() == 0), int'(empty));
			checkValue("reqReady", int'(readyExp), int'(reqReady));
			reqFire = reqValid && reqReady;
			relFire = relValid && relReady;
			allocIdx = -1;
			// Response leaving the register
			if (rspValid && rspReady && expDstQ.size() != 0) begin
				checkValue("rspDst", int'(expDstQ.pop_front()), int'(rspDst));
				checkValue("rspSrc", int'(expSrcQ.pop_front()), int'(rspSrc));
			end
			// Lookup and allocation see the state before this edge's release
			if (reqFire) begin
				expectedResponse(reqDst, reqSrc, newDst, newSrc);
				if (insideWindow(reqDst)) allocIdx = lowestFree();
			end
			if (relFire && modelDst.size() != 0) begin
				if (modelBuf[0] >= 0) busy[modelBuf[0]] = 1'b0;
				void'(modelDst.pop_front());
				void'(modelPhys.pop_front());
				void'(modelBuf.pop_front());
			end
			if (reqFire) begin
				expDstQ.push_back(newDst);
				expSrcQ.push_back(newSrc);
				modelDst.push_back(reqDst);
				modelPhys.push_back(newDst);
				modelBuf.push_back(allocIdx);
				if (allocIdx >= 0) busy[allocIdx] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/renameUnitTb.sv
////////////////////////////////////////
// Testbench for the rename unit
// Clock, reset, directed and random
// stimulus, DUT and checker instances
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module renameUnitTb;

	logic clock;
	logic reset;
	logic reqValid;
	logic reqReady;
	renameIdPkg::archId_t reqDst;
	renameIdPkg::archId_t reqSrc;
	logic rspValid;
	logic rspReady;
	renameIdPkg::archId_t rspDst;
	renameIdPkg::archId_t rspSrc;
	logic relValid;
	logic relReady;
	logic full;
	logic empty;

	int seed;
	int timeoutCount;
	int testChecks;
	int testErrors;
	int waitLimit = 40;
	logic [31:0] r;
	logic reqFired;
	logic relFired;

	renameUnit UUT (
		.clock(clock), .reset(reset),
		.reqValid(reqValid), .reqReady(reqReady), .reqDst(reqDst), .reqSrc(reqSrc),
		.rspValid(rspValid), .rspReady(rspReady), .rspDst(rspDst), .rspSrc(rspSrc),
		.relValid(relValid), .relReady(relReady), .full(full), .empty(empty)
	);

	renameChecker check (
		.clock(clock), .reset(reset),
		.reqValid(reqValid), .reqReady(reqReady), .reqDst(reqDst), .reqSrc(reqSrc),
		.rspValid(rspValid), .rspReady(rspReady), .rspDst(rspDst), .rspSrc(rspSrc),
		.relValid(relValid), .relReady(relReady), .full(full), .empty(empty)
	);

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// Stimulus tasks

	// Inputs change 2 ns after the rising edge
	task automatic stepCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic sendRequest(input renameIdPkg::archId_t dst, input renameIdPkg::archId_t src);
		int waited;
		logic fired;
		waited = 0;
		fired = 1'b0;
		reqValid = 1'b1;
		reqDst = dst;
		reqSrc = src;
		while (!fired && waited < waitLimit) begin
			@(negedge clock);
			fired = reqReady;
			stepCycle();
			waited++;
		end
		reqValid = 1'b0;
		if (!fired) begin
			timeoutCount++;
			$display("timeout: request with destination %0d was never accepted", dst);
		end
	endtask

	task automatic releaseOne();
		int waited;
		logic fired;
		waited = 0;
		fired = 1'b0;
		relValid = 1'b1;
		while (!fired && waited < waitLimit) begin
			@(negedge clock);
			fired = relReady;
			stepCycle();
			waited++;
		end
		relValid = 1'b0;
		if (!fired) begin
			timeoutCount++;
			$display("timeout: release was never accepted");
		end
	endtask

	// Retire every entry, then let the last response leave
	task automatic drainTable();
		int guard;
		guard = 0;
		while (!empty && guard < 20) begin
			releaseOne();
			guard++;
		end
		if (!empty) begin
			timeoutCount++;
			$display("timeout: table did not drain to empty");
		end
		stepCycle();
	endtask

	task automatic startTest(input string name);
		check.testName = name;
		testChecks = check.checkCount;
		testErrors = check.errorCount;
	endtask

	task automatic finishTest(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			check.checkCount - testChecks, check.errorCount - testErrors);
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 45997;
		timeoutCount = 0;
		reset = 1'b1;
		reqValid = 1'b0;
		reqDst = '0;
		reqSrc = '0;
		rspReady = 1'b1;
		relValid = 1'b0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		// IDs outside the window and sources without producers
		startTest("passThrough");
		sendRequest(5'd3, 5'd2);
		sendRequest(5'd30, 5'd5);
		drainTable();
		finishTest("passThrough");

		startTest("ascendingAlloc");
		sendRequest(5'd10, 5'd0);
		sendRequest(5'd11, 5'd0);
		sendRequest(5'd12, 5'd0);
		drainTable();
		finishTest("ascendingAlloc");

		// Second write of 20 shadows the first
		startTest("youngestProducer");
		sendRequest(5'd20, 5'd1);
		sendRequest(5'd20, 5'd20);
		sendRequest(5'd5, 5'd20);
		drainTable();
		finishTest("youngestProducer");

		startTest("fullAndRelease");
		for (int i = 0; i < 8; i++) begin
			sendRequest(renameIdPkg::archId_t'(8 + i), renameIdPkg::archId_t'(i));
		end
		// Held request while full
		reqValid = 1'b1;
		reqDst = 5'd20;
		reqSrc = 5'd9;
		for (int i = 0; i < 4; i++) stepCycle();
		// Buffer 0 comes back and goes to the held request
		releaseOne();
		sendRequest(5'd20, 5'd9);
		drainTable();
		finishTest("fullAndRelease");

		startTest("backPressure");
		rspReady = 1'b0;
		sendRequest(5'd12, 5'd3);
		reqValid = 1'b1;
		reqDst = 5'd13;
		reqSrc = 5'd12;
		for (int i = 0; i < 5; i++) stepCycle();
		rspReady = 1'b1;
		sendRequest(5'd13, 5'd12);
		drainTable();
		finishTest("backPressure");

		// Random requests, releases and response stalls
		startTest("randomMix");
		for (int n = 0; n < 300; n++) begin
			r = $random(seed);
			if (!reqValid && r[0]) begin
				reqValid = 1'b1;
				reqDst = r[20:16];
				reqSrc = r[12:8];
			end
			if (!relValid) relValid = (r[3:2] == 2'b00);
			rspReady = (r[5:4] != 2'b00);
			@(negedge clock);
			reqFired = reqValid && reqReady;
			relFired = relValid && relReady;
			stepCycle();
			if (reqFired) reqValid = 1'b0;
			if (relFired) relValid = 1'b0;
		end
		// Finish any transfer still in progress
		rspReady = 1'b1;
		if (reqValid) sendRequest(reqDst, reqSrc);
		if (relValid) releaseOne();
		drainTable();
		finishTest("randomMix");

		$display("summary: %0d checks, %0d errors, %0d timeouts",
			check.checkCount, check.errorCount, timeoutCount);
		if (check.errorCount == 0 && timeoutCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: renameUnit.f
hw/renameIdPkg.sv
hw/renameTablePkg.sv
hw/freeBufferList.sv
hw/renameTable.sv
hw/sourceLookup.sv
hw/renameIssue.sv
hw/renameUnit.sv
sim/renameChecker.sv
sim/renameUnitTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the rename unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module renameUnitTb \
	-f renameUnit.f \
	-o renameUnitSim

./obj_dir/renameUnitSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	echo "run passed"
	exit 0
else
	echo "run failed"
	exit 1
fi
